/* dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

  ////////////////////
  // address layout
  ////////////////////

  localparam int addr_w = 32;
  localparam int set_bits = 4;
  localparam int tag_bits = addr_w - set_bits - 3;

  typedef logic [63:0] data_word_t;
  typedef logic [tag_bits-1:0] tag_t;
  typedef logic [set_bits-1:0] index_t;

  typedef struct packed {
    tag_t tag;
    index_t index;
    logic [2:0] offset;
  } addr_fields_t;

  // raw word for the bus, fields for the lookup
  typedef union packed {
    logic [addr_w-1:0] raw;
    addr_fields_t f;
  } cache_addr_u;

  // memory port write enable levels
  localparam logic wb_read = 1'b0;
  localparam logic wb_write = 1'b1;

endpackage

`default_nettype wire

/* cache_store.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_store
  import dcache_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  index_t     lookup_index,
  input  tag_t       lookup_tag,
  output logic       hit,
  output logic       hit_way,
  output data_word_t hit_data,
  output logic       victim_way,
  output logic       victim_dirty,
  output tag_t       victim_tag,
  output data_word_t victim_data,
  input  logic       wr_en,
  input  logic       wr_way,
  input  logic       wr_dirty,
  input  tag_t       wr_tag,
  input  data_word_t wr_data,
  input  logic       touch
);

  localparam int num_sets = 2 ** set_bits;

  tag_t                tag_mem  [2][num_sets];
  data_word_t          data_mem [2][num_sets];
  logic [num_sets-1:0] valid    [2];
  logic [num_sets-1:0] dirty    [2];
  // way to replace next, per set
  logic [num_sets-1:0] lru;
  logic [1:0]          way_hit;

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = valid[w][lookup_index] && (tag_mem[w][lookup_index] == lookup_tag);
    end
  end

  assign hit      = |way_hit;
  assign hit_way  = way_hit[1];
  assign hit_data = data_mem[hit_way][lookup_index];

  // empty way first, then lru
  always_comb begin
    if (!valid[0][lookup_index]) begin
      victim_way = 1'b0;
    end else if (!valid[1][lookup_index]) begin
      victim_way = 1'b1;
    end else begin
      victim_way = lru[lookup_index];
    end
  end

  assign victim_dirty = valid[victim_way][lookup_index] && dirty[victim_way][lookup_index];
  assign victim_tag   = tag_mem[victim_way][lookup_index];
  assign victim_data  = data_mem[victim_way][lookup_index];

  always_ff @(posedge clock) begin
    if (wr_en) begin
      tag_mem[wr_way][lookup_index]  <= wr_tag;
      data_mem[wr_way][lookup_index] <= wr_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '{default: '0};
      dirty <= '{default: '0};
      lru   <= '0;
    end else if (wr_en) begin
      valid[wr_way][lookup_index] <= 1'b1;
      dirty[wr_way][lookup_index] <= wr_dirty;
      lru[lookup_index]           <= ~wr_way;
    end else if (touch) begin
      lru[lookup_index] <= ~hit_way;
    end
  end

endmodule

`default_nettype wire

/* dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        cpu_cyc,
  input  logic        cpu_stb,
  input  logic        cpu_we,
  input  cache_addr_u cpu_adr,
  input  data_word_t  cpu_dat_w,
  output data_word_t  cpu_dat_r,
  output logic        cpu_ack,
  output index_t      lookup_index,
  output tag_t        lookup_tag,
  input  logic        hit,
  input  logic        hit_way,
  input  data_word_t  hit_data,
  input  logic        victim_way,
  input  logic        victim_dirty,
  input  tag_t        victim_tag,
  input  data_word_t  victim_data,
  output logic        wr_en,
  output logic        wr_way,
  output logic        wr_dirty,
  output tag_t        wr_tag,
  output data_word_t  wr_data,
  output logic        touch,
  output logic        push,
  output cache_addr_u push_adr,
  output data_word_t  push_dat,
  input  logic        full,
  input  logic        wb_empty,
  output logic        fill_cyc,
  output logic        fill_stb,
  output cache_addr_u fill_adr,
  input  data_word_t  fill_dat_r,
  input  logic        fill_ack
);

  typedef enum logic [1:0] {idle, evict, refill, respond} state_t;

  state_t state;
  state_t state_next;
  logic   req;
  logic   victim_ok;
  logic   allocate;

  assign req          = cpu_cyc && cpu_stb && !cpu_ack;
  assign lookup_index = cpu_adr.f.index;
  assign lookup_tag   = cpu_adr.f.tag;

  ////////////////////
  // miss handling
  ////////////////////

  // victim can leave now
  assign victim_ok = !victim_dirty || !full;
  assign allocate  = (((state == idle) && req && !hit) || (state == evict)) && victim_ok;

  assign push     = allocate && victim_dirty;
  assign push_dat = victim_data;

  always_comb begin
    push_adr.f.tag    = victim_tag;
    push_adr.f.index  = cpu_adr.f.index;
    push_adr.f.offset = '0;
  end

  // refill waits behind the write buffer
  assign fill_cyc     = (state == refill) && wb_empty;
  assign fill_stb     = fill_cyc;
  assign fill_adr.raw = {cpu_adr.raw[addr_w-1:3], 3'b000};

  ////////////////////
  // store write port
  ////////////////////

  assign wr_en = ((state == idle) && req && hit && cpu_we) || (allocate && cpu_we) ||
                 ((state == refill) && fill_ack);
  assign wr_way   = hit ? hit_way : victim_way;
  assign wr_dirty = cpu_we;
  assign wr_tag   = cpu_adr.f.tag;
  assign wr_data  = cpu_we ? cpu_dat_w : fill_dat_r;
  assign touch    = (state == idle) && req && hit && !cpu_we;

  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (req) begin
          if (hit || (victim_ok && cpu_we)) begin
            state_next = respond;
          end else if (!victim_ok) begin
            state_next = evict;
          end else begin
            state_next = refill;
          end
        end
      end
      evict: begin
        if (victim_ok) begin
          state_next = cpu_we ? respond : refill;
        end
      end
      refill: begin
        if (fill_ack) begin
          state_next = respond;
        end
      end
      default: state_next = idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= idle;
      cpu_ack <= 1'b0;
    end else begin
      state   <= state_next;
      cpu_ack <= (state == respond);
    end
  end

  always_ff @(posedge clock) begin
    if ((state == idle) && req && hit) begin
      cpu_dat_r <= hit_data;
    end else if ((state == refill) && fill_ack) begin
      cpu_dat_r <= fill_dat_r;
    end
  end

endmodule

`default_nettype wire

/* write_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module write_buffer
  import dcache_pkg::*;
#(
  parameter int wb_depth = 2
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        push,
  input  cache_addr_u push_adr,
  input  data_word_t  push_dat,
  output logic        full,
  output logic        wb_empty,
  output logic        wr_cyc,
  output logic        wr_stb,
  output cache_addr_u wr_adr,
  output data_word_t  wr_dat,
  input  logic        wr_ack
);

  localparam int ptr_w = (wb_depth > 1) ? $clog2(wb_depth) : 1;
  localparam int cnt_w = $clog2(wb_depth + 1);

  cache_addr_u      adr_q [wb_depth];
  data_word_t       dat_q [wb_depth];
  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  logic [cnt_w-1:0] count;
  logic             pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(wb_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign pop      = wr_ack && !wb_empty;
  assign full     = (count == cnt_w'(wb_depth));
  assign wb_empty = (count == '0);

  // head entry goes out whenever there is one
  assign wr_cyc = !wb_empty;
  assign wr_stb = !wb_empty;
  assign wr_adr = adr_q[head];
  assign wr_dat = dat_q[head];

  always_ff @(posedge clock) begin
    if (push) begin
      adr_q[tail] <= push_adr;
      dat_q[tail] <= push_dat;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= next_ptr(tail);
      end
      if (pop) begin
        head <= next_ptr(head);
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
  import dcache_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  logic              wr_cyc,
  input  logic              wr_stb,
  input  cache_addr_u       wr_adr,
  input  data_word_t        wr_dat,
  output logic              wr_ack,
  input  logic              fill_cyc,
  input  logic              fill_stb,
  input  cache_addr_u       fill_adr,
  output data_word_t        fill_dat_r,
  output logic              fill_ack,
  output logic              mem_cyc,
  output logic              mem_stb,
  output logic              mem_we,
  output logic [addr_w-1:0] mem_adr,
  output data_word_t        mem_dat_w,
  input  data_word_t        mem_dat_r,
  input  logic              mem_ack
);

  logic busy;
  logic grant_wb;
  logic wr_req;
  logic fill_req;

  assign wr_req   = wr_cyc && wr_stb;
  assign fill_req = fill_cyc && fill_stb;

  // grant only from idle, write buffer first
  always_ff @(posedge clock) begin
    if (reset) begin
      busy     <= 1'b0;
      grant_wb <= 1'b0;
    end else if (!busy) begin
      if (wr_req) begin
        busy     <= 1'b1;
        grant_wb <= 1'b1;
      end else if (fill_req) begin
        busy     <= 1'b1;
        grant_wb <= 1'b0;
      end
    end else if (mem_ack) begin
      busy <= 1'b0;
    end
  end

  assign mem_cyc   = busy;
  assign mem_stb   = busy;
  assign mem_we    = (busy && grant_wb) ? wb_write : wb_read;
  assign mem_adr   = grant_wb ? wr_adr.raw : fill_adr.raw;
  assign mem_dat_w = wr_dat;

  assign fill_dat_r = mem_dat_r;
  assign wr_ack     = busy && grant_wb && mem_ack;
  assign fill_ack   = busy && !grant_wb && mem_ack;

endmodule

`default_nettype wire

/* dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top
  import dcache_pkg::*;
#(
  parameter int wb_depth = 2
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              cpu_cyc,
  input  logic              cpu_stb,
  input  logic              cpu_we,
  input  logic [addr_w-1:0] cpu_adr,
  input  data_word_t        cpu_dat_w,
  output data_word_t        cpu_dat_r,
  output logic              cpu_ack,
  output logic              mem_cyc,
  output logic              mem_stb,
  output logic              mem_we,
  output logic [addr_w-1:0] mem_adr,
  output data_word_t        mem_dat_w,
  input  data_word_t        mem_dat_r,
  input  logic              mem_ack
);

  cache_addr_u cpu_addr;
  index_t      lookup_index;
  tag_t        lookup_tag;
  logic        hit;
  logic        hit_way;
  data_word_t  hit_data;
  logic        victim_way;
  logic        victim_dirty;
  tag_t        victim_tag;
  data_word_t  victim_data;
  logic        store_wr_en;
  logic        store_wr_way;
  logic        store_wr_dirty;
  tag_t        store_wr_tag;
  data_word_t  store_wr_data;
  logic        touch;

  logic        push;
  cache_addr_u push_adr;
  data_word_t  push_dat;
  logic        full;
  logic        wb_empty;

  logic        fill_cyc;
  logic        fill_stb;
  cache_addr_u fill_adr;
  data_word_t  fill_dat_r;
  logic        fill_ack;
  logic        wr_cyc;
  logic        wr_stb;
  cache_addr_u wr_adr;
  data_word_t  wr_dat;
  logic        wr_ack;

  assign cpu_addr.raw = cpu_adr;

  cache_store cache_store_i (
    .clock        (clock),
    .reset        (reset),
    .lookup_index (lookup_index),
    .lookup_tag   (lookup_tag),
    .hit          (hit),
    .hit_way      (hit_way),
    .hit_data     (hit_data),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_data  (victim_data),
    .wr_en        (store_wr_en),
    .wr_way       (store_wr_way),
    .wr_dirty     (store_wr_dirty),
    .wr_tag       (store_wr_tag),
    .wr_data      (store_wr_data),
    .touch        (touch)
  );

  dcache_ctrl dcache_ctrl_i (
    .clock        (clock),
    .reset        (reset),
    .cpu_cyc      (cpu_cyc),
    .cpu_stb      (cpu_stb),
    .cpu_we       (cpu_we),
    .cpu_adr      (cpu_addr),
    .cpu_dat_w    (cpu_dat_w),
    .cpu_dat_r    (cpu_dat_r),
    .cpu_ack      (cpu_ack),
    .lookup_index (lookup_index),
    .lookup_tag   (lookup_tag),
    .hit          (hit),
    .hit_way      (hit_way),
    .hit_data     (hit_data),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_data  (victim_data),
    .wr_en        (store_wr_en),
    .wr_way       (store_wr_way),
    .wr_dirty     (store_wr_dirty),
    .wr_tag       (store_wr_tag),
    .wr_data      (store_wr_data),
    .touch        (touch),
    .push         (push),
    .push_adr     (push_adr),
    .push_dat     (push_dat),
    .full         (full),
    .wb_empty     (wb_empty),
    .fill_cyc     (fill_cyc),
    .fill_stb     (fill_stb),
    .fill_adr     (fill_adr),
    .fill_dat_r   (fill_dat_r),
    .fill_ack     (fill_ack)
  );

  write_buffer #(
    .wb_depth (wb_depth)
  ) write_buffer_i (
    .clock    (clock),
    .reset    (reset),
    .push     (push),
    .push_adr (push_adr),
    .push_dat (push_dat),
    .full     (full),
    .wb_empty (wb_empty),
    .wr_cyc   (wr_cyc),
    .wr_stb   (wr_stb),
    .wr_adr   (wr_adr),
    .wr_dat   (wr_dat),
    .wr_ack   (wr_ack)
  );

  mem_arbiter mem_arbiter_i (
    .clock      (clock),
    .reset      (reset),
    .wr_cyc     (wr_cyc),
    .wr_stb     (wr_stb),
    .wr_adr     (wr_adr),
    .wr_dat     (wr_dat),
    .wr_ack     (wr_ack),
    .fill_cyc   (fill_cyc),
    .fill_stb   (fill_stb),
    .fill_adr   (fill_adr),
    .fill_dat_r (fill_dat_r),
    .fill_ack   (fill_ack),
    .mem_cyc    (mem_cyc),
    .mem_stb    (mem_stb),
    .mem_we     (mem_we),
    .mem_adr    (mem_adr),
    .mem_dat_w  (mem_dat_w),
    .mem_dat_r  (mem_dat_r),
    .mem_ack    (mem_ack)
  );

endmodule

`default_nettype wire

/* mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_model
  import dcache_pkg::*;
#(
  parameter int         mem_words = 1024,
  parameter data_word_t fill_key  = 64'h0
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              mem_cyc,
  input  logic              mem_stb,
  input  logic              mem_we,
  input  logic [addr_w-1:0] mem_adr,
  input  data_word_t        mem_dat_w,
  output data_word_t        mem_dat_r,
  output logic              mem_ack
);

  localparam int idx_w = $clog2(mem_words);

  data_word_t        mem [mem_words];
  integer            seed;
  logic              pending;
  int                remaining;
  logic [idx_w-1:0]  idx;
  logic [addr_w-1:0] byte_adr;

  assign idx = mem_adr[3 +: idx_w];

  // every word starts as its own address xor the key
  initial begin
    seed      = 32'h3e45;
    mem_ack   = 1'b0;
    mem_dat_r = '0;
    for (int i = 0; i < mem_words; i++) begin
      byte_adr = addr_w'(i * 8);
      mem[i]   = {byte_adr, byte_adr} ^ fill_key;
    end
  end

  always @(posedge clock) begin : respond
    logic fire;
    int   delay;
    fire  = 1'b0;
    delay = 0;
    if (reset) begin
      mem_ack   <= 1'b0;
      pending   <= 1'b0;
      remaining <= 0;
    end else begin
      mem_ack <= 1'b0;
      if (mem_cyc && mem_stb && !mem_ack) begin
        // ack after 1 to 3 cycles
        if (!pending) begin
          delay = $unsigned($random(seed)) % 3;
          if (delay == 0) begin
            fire = 1'b1;
          end else begin
            pending   <= 1'b1;
            remaining <= delay - 1;
          end
        end else if (remaining == 0) begin
          fire = 1'b1;
        end else begin
          remaining <= remaining - 1;
        end
      end
      if (fire) begin
        mem_ack   <= 1'b1;
        pending   <= 1'b0;
        mem_dat_r <= mem[idx];
        if (mem_we) begin
          mem[idx] <= mem_dat_w;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dcache_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_sva
  import dcache_pkg::*;
(
  input logic              clock,
  input logic              reset,
  input logic              cpu_stb,
  input logic              cpu_ack,
  input logic              mem_stb,
  input logic              mem_we,
  input logic              mem_ack,
  input logic [addr_w-1:0] mem_adr
);

  ////////////////////
  // processor port
  ////////////////////

  ack_needs_stb: assert property (@(posedge clock) disable iff (reset)
    cpu_ack |-> cpu_stb)
    else $error("cpu_ack high without cpu_stb");

  ack_single_cycle: assert property (@(posedge clock) disable iff (reset)
    cpu_ack |=> !cpu_ack)
    else $error("cpu_ack high on two cycles in a row");

  ////////////////////
  // memory port
  ////////////////////

  stb_held: assert property (@(posedge clock) disable iff (reset)
    (mem_stb && !mem_ack) |=> mem_stb)
    else $error("mem_stb dropped before mem_ack");

  request_stable: assert property (@(posedge clock) disable iff (reset)
    (mem_stb && !mem_ack) |=> ($stable(mem_adr) && $stable(mem_we)))
    else $error("mem_adr or mem_we changed while waiting for mem_ack");

endmodule

bind dcache_top dcache_sva dcache_sva_i (
  .clock   (clock),
  .reset   (reset),
  .cpu_stb (cpu_stb),
  .cpu_ack (cpu_ack),
  .mem_stb (mem_stb),
  .mem_we  (mem_we),
  .mem_ack (mem_ack),
  .mem_adr (mem_adr)
);

`default_nettype wire

/* tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
  import dcache_pkg::*;
();

  localparam int         clock_period  = 20;
  localparam int         mem_words     = 1024;
  localparam int         idx_w         = $clog2(mem_words);
  localparam int         buffer_depth  = 2;
  localparam data_word_t fill_key      = 64'h5a5a_c3c3_0f0f_9696;
  localparam int         ack_limit     = 40;
  localparam int         random_ops    = 200;
  localparam int         num_ops       = 8 + random_ops;
  localparam int         cycles_per_op = 40;

  localparam logic [addr_w-1:0] addr_a  = 32'h0000_0040;
  // set 3, tags 0, 1 and 2
  localparam logic [addr_w-1:0] addr_b1 = 32'h0000_0018;
  localparam logic [addr_w-1:0] addr_b2 = 32'h0000_0098;
  localparam logic [addr_w-1:0] addr_b3 = 32'h0000_0118;

  logic              clock;
  logic              reset;
  logic              cpu_cyc;
  logic              cpu_stb;
  logic              cpu_we;
  logic [addr_w-1:0] cpu_adr;
  data_word_t        cpu_dat_w;
  data_word_t        cpu_dat_r;
  logic              cpu_ack;
  logic              mem_cyc;
  logic              mem_stb;
  logic              mem_we;
  logic [addr_w-1:0] mem_adr;
  data_word_t        mem_dat_w;
  data_word_t        mem_dat_r;
  logic              mem_ack;

  data_word_t        ref_mem [mem_words];
  integer            seed;
  int                errors;
  int                tests_run;
  int                test_errors_start;
  int                mem_reads;
  int                mem_writes;
  logic [addr_w-1:0] last_wr_adr;
  data_word_t        last_wr_dat;
  string             test_name;

  dcache_top #(
    .wb_depth (buffer_depth)
  ) dcache_top_i (
    .clock     (clock),
    .reset     (reset),
    .cpu_cyc   (cpu_cyc),
    .cpu_stb   (cpu_stb),
    .cpu_we    (cpu_we),
    .cpu_adr   (cpu_adr),
    .cpu_dat_w (cpu_dat_w),
    .cpu_dat_r (cpu_dat_r),
    .cpu_ack   (cpu_ack),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_we    (mem_we),
    .mem_adr   (mem_adr),
    .mem_dat_w (mem_dat_w),
    .mem_dat_r (mem_dat_r),
    .mem_ack   (mem_ack)
  );

  mem_model #(
    .mem_words (mem_words),
    .fill_key  (fill_key)
  ) mem_model_i (
    .clock     (clock),
    .reset     (reset),
    .mem_cyc   (mem_cyc),
    .mem_stb   (mem_stb),
    .mem_we    (mem_we),
    .mem_adr   (mem_adr),
    .mem_dat_w (mem_dat_w),
    .mem_dat_r (mem_dat_r),
    .mem_ack   (mem_ack)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  // memory port monitor, ack is one cycle wide
  always @(negedge clock) begin
    if (!reset && mem_cyc && mem_stb && mem_ack) begin
      if (mem_we) begin
        mem_writes  <= mem_writes + 1;
        last_wr_adr <= mem_adr;
        last_wr_dat <= mem_dat_w;
      end else begin
        mem_reads <= mem_reads + 1;
      end
    end
  end

  initial begin
    #(num_ops * cycles_per_op * clock_period);
    $display("watchdog expired after %0d cycles", num_ops * cycles_per_op);
    $display("Something failed");
    $finish;
  end

  function automatic data_word_t init_word(input logic [addr_w-1:0] adr);
    return {adr, adr} ^ fill_key;
  endfunction

  function automatic data_word_t ref_word(input logic [addr_w-1:0] adr);
    return ref_mem[adr[3 +: idx_w]];
  endfunction

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_word(input string what, input data_word_t expected,
                            input data_word_t actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_addr(input string what, input logic [addr_w-1:0] expected,
                            input logic [addr_w-1:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    if (actual != expected) begin
      errors++;
      $display("mismatch in %s, %s: expected %0d, actual %0d", test_name, what, expected,
               actual);
    end
  endtask

  ////////////////////
  // processor bus
  ////////////////////

  task automatic cpu_access(input logic we, input logic [addr_w-1:0] adr,
                            input data_word_t dat_w, output data_word_t dat_r);
    int   waited;
    logic acked;
    dat_r  = '0;
    acked  = 1'b0;
    waited = 0;
    @(negedge clock);
    cpu_cyc   = 1'b1;
    cpu_stb   = 1'b1;
    cpu_we    = we;
    cpu_adr   = adr;
    cpu_dat_w = dat_w;
    while (!acked && (waited < ack_limit)) begin
      @(negedge clock);
      waited++;
      if (cpu_ack) begin
        acked = 1'b1;
        dat_r = cpu_dat_r;
      end
    end
    if (!acked) begin
      errors++;
      $display("%s: no ack from the DUT for the access to %h", test_name, adr);
    end
    // hold through the edge that samples the ack
    @(negedge clock);
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    cpu_we  = 1'b0;
  endtask

  task automatic cpu_write(input logic [addr_w-1:0] adr, input data_word_t dat);
    data_word_t unused;
    cpu_access(1'b1, adr, dat, unused);
    ref_mem[adr[3 +: idx_w]] = dat;
  endtask

  task automatic cpu_read(input logic [addr_w-1:0] adr, output data_word_t dat);
    cpu_access(1'b0, adr, '0, dat);
  endtask

  task automatic start_test(input string name);
    test_name         = name;
    test_errors_start = errors;
    tests_run++;
  endtask

  task automatic finish_test();
    if (errors == test_errors_start) begin
      $display("test %s passed", test_name);
    end else begin
      $display("test %s failed with %0d errors", test_name, errors - test_errors_start);
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic read_miss_then_hit();
    data_word_t rd;
    int         r0;
    int         w0;
    start_test("read_miss_then_hit");
    r0 = mem_reads;
    w0 = mem_writes;
    cpu_read(addr_a, rd);
    check_word("first read", init_word(addr_a), rd);
    check_count("memory reads on miss", 1, mem_reads - r0);
    check_count("memory writes on miss", 0, mem_writes - w0);
    r0 = mem_reads;
    w0 = mem_writes;
    cpu_read(addr_a, rd);
    check_word("second read", init_word(addr_a), rd);
    check_count("memory cycles on hit", 0, (mem_reads - r0) + (mem_writes - w0));
    finish_test();
  endtask

  task automatic write_hit();
    data_word_t rd;
    int         r0;
    int         w0;
    start_test("write_hit");
    r0 = mem_reads;
    w0 = mem_writes;
    cpu_write(addr_a, 64'h0123_4567_89ab_cdef);
    cpu_read(addr_a, rd);
    check_word("read back", ref_word(addr_a), rd);
    check_count("memory writes", 0, mem_writes - w0);
    check_count("memory reads", 0, mem_reads - r0);
    finish_test();
  endtask

  task automatic dirty_eviction();
    int waited;
    int r0;
    int w0;
    start_test("dirty_eviction");
    r0 = mem_reads;
    w0 = mem_writes;
    cpu_write(addr_b1, 64'hb1b1_0000_1111_0001);
    cpu_write(addr_b2, 64'hb2b2_0000_2222_0002);
    // both ways full, b1 is least recently used
    cpu_write(addr_b3, 64'hb3b3_0000_3333_0003);
    waited = 0;
    while ((mem_writes == w0) && (waited < ack_limit)) begin
      @(posedge clock);
      waited++;
    end
    if (mem_writes == w0) begin
      errors++;
      $display("%s: the evicted line never reached memory", test_name);
    end
    check_count("memory writes", 1, mem_writes - w0);
    check_count("memory reads", 0, mem_reads - r0);
    check_addr("writeback address", addr_b1, last_wr_adr);
    check_word("writeback data", ref_word(addr_b1), last_wr_dat);
    finish_test();
  endtask

  task automatic read_after_eviction();
    data_word_t rd;
    int         r0;
    int         w0;
    start_test("read_after_eviction");
    r0 = mem_reads;
    w0 = mem_writes;
    // victim is b2, dirty, so its writeback must drain first
    cpu_read(addr_b1, rd);
    check_word("re-read", ref_word(addr_b1), rd);
    check_count("memory reads", 1, mem_reads - r0);
    check_count("memory writes", 1, mem_writes - w0);
    check_addr("writeback address", addr_b2, last_wr_adr);
    finish_test();
  endtask

  task automatic random_traffic();
    logic [31:0]       r_ctl;
    logic [31:0]       r_hi;
    logic [31:0]       r_lo;
    logic [addr_w-1:0] adr;
    data_word_t        rd;
    start_test("random_traffic");
    for (int i = 0; i < random_ops; i++) begin
      r_ctl = $random(seed);
      // 64 words, four tags in each of the 16 sets
      adr = {23'b0, r_ctl[5:0], 3'b000};
      if (r_ctl[8]) begin
        r_hi = $random(seed);
        r_lo = $random(seed);
        cpu_write(adr, {r_hi, r_lo});
      end else begin
        cpu_read(adr, rd);
        check_word($sformatf("read %0d at %h", i, adr), ref_word(adr), rd);
      end
    end
    finish_test();
  endtask

  initial begin
    reset     = 1'b1;
    cpu_cyc   = 1'b0;
    cpu_stb   = 1'b0;
    cpu_we    = 1'b0;
    cpu_adr   = '0;
    cpu_dat_w = '0;
    seed      = 32'h3e45;
    errors    = 0;
    tests_run = 0;
    for (int i = 0; i < mem_words; i++) begin
      ref_mem[i] = init_word(addr_w'(i * 8));
    end
    repeat (3) @(negedge clock);
    reset = 1'b0;

    read_miss_then_hit();
    write_hit();
    dirty_eviction();
    read_after_eviction();
    random_traffic();

    $display("tests %0d, errors %0d, memory reads %0d, memory writes %0d",
             tests_run, errors, mem_reads, mem_writes);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
dcache_pkg.sv
cache_store.sv
dcache_ctrl.sv
write_buffer.sv
mem_arbiter.sv
dcache_top.sv
mem_model.sv
dcache_sva.sv
tb_dcache.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Everything OK

SRCS := $(wildcard *.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
